//--- src/zx_mem_pkg.sv
package zx_mem_pkg;

	// ====================
	// Widths and types
	// ====================
	localparam int RAM_ADDR_W = 23;
	localparam int BANK_W     = 14;  // Offset inside a 16 KB bank

	typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [7:0]            byte_t;
	typedef logic [15:0]           cpu_addr_t;

	// Fixed banks behind windows 4000 and 8000
	localparam logic [2:0] RAM_BANK_5 = 3'd5;
	localparam logic [2:0] RAM_BANK_2 = 3'd2;

	// ROM 0 here, ROM 1 one bank above
	localparam ram_addr_t ROM_AREA = 23'h150000;

	localparam byte_t LOAD_IDX_ROM  = 8'd0;
	localparam byte_t LOAD_IDX_TAPE = 8'd2;

	// ====================
	// Address map helpers
	// ====================
	function automatic ram_addr_t bank_addr(input logic [2:0] bank,
		input logic [BANK_W-1:0] ofs);
		return {{(RAM_ADDR_W-3-BANK_W){1'b0}}, bank, ofs};
	endfunction

	function automatic ram_addr_t rom_addr(input logic rom_sel,
		input logic [BANK_W-1:0] ofs);
		ram_addr_t rel;
		rel = {{(RAM_ADDR_W-1-BANK_W){1'b0}}, rom_sel, ofs};
		return ROM_AREA + rel;
	endfunction

	// Both ROM images, 32 KB in total
	function automatic logic in_rom_area(input ram_addr_t a);
		return (a >= ROM_AREA) && (a < ROM_AREA + (ram_addr_t'(2) << BANK_W));
	endfunction

endpackage

//--- src/mem_req_if.sv
`timescale 1ns/1ps

// One request/acknowledge RAM channel
interface mem_req_if
	import zx_mem_pkg::*;
();

	logic      req;    // Held with stable fields until ack
	logic      we;
	ram_addr_t addr;
	byte_t     wdata;
	logic      ack;    // One-cycle pulse
	byte_t     rdata;  // Valid in the ack cycle

	modport requester (
		output req, we, addr, wdata,
		input  ack, rdata
	);

	modport server (
		input  req, we, addr, wdata,
		output ack, rdata
	);

endinterface

//--- src/page_mapper.sv
`timescale 1ns/1ps

module page_mapper
	import zx_mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_mreq,
	input  logic      cpu_rd,
	input  logic      cpu_wr,
	input  logic      cpu_iorq,
	input  byte_t     cpu_dout,
	output byte_t     cpu_din,
	output logic      cpu_wait,
	mem_req_if.requester mem
);

	byte_t     page_reg;  // Port 7FFD
	logic      mreq_d;
	logic      iorq_d;
	ram_addr_t map_addr;

	wire page_lock = page_reg[5];
	wire mem_start = cpu_mreq & ~mreq_d & (cpu_rd | cpu_wr) & ~cpu_wait;
	wire rom_wr    = cpu_wr & (cpu_addr[15:14] == 2'b00);  // Dropped, never reaches RAM
	wire io_start  = cpu_iorq & ~iorq_d & cpu_wr;
	wire page_sel  = ~cpu_addr[15] & ~cpu_addr[1];

	// ====================
	// CPU address map
	// ====================
	always_comb begin
		case (cpu_addr[15:14])
			2'b00:   map_addr = rom_addr(page_reg[4], cpu_addr[BANK_W-1:0]);
			2'b01:   map_addr = bank_addr(RAM_BANK_5, cpu_addr[BANK_W-1:0]);
			2'b10:   map_addr = bank_addr(RAM_BANK_2, cpu_addr[BANK_W-1:0]);
			default: map_addr = bank_addr(page_reg[2:0], cpu_addr[BANK_W-1:0]);
		endcase
	end

	// Paging register, frozen once bit 5 is set
	always_ff @(posedge clk_sys) begin
		iorq_d <= cpu_iorq;
		if (reset) begin
			page_reg <= '0;
		end else if (io_start && page_sel && !page_lock) begin
			page_reg <= cpu_dout;
		end
	end

	// ====================
	// Request and wait
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mreq_d   <= 1'b0;
			mem.req  <= 1'b0;
			cpu_wait <= 1'b0;
		end else begin
			mreq_d <= cpu_mreq;
			if (mem_start) begin
				cpu_wait <= 1'b1;
				mem.req  <= ~rom_wr;
			end else if (mem.req && mem.ack) begin
				mem.req  <= 1'b0;
				cpu_wait <= 1'b0;
			end else if (cpu_wait && !mem.req) begin
				cpu_wait <= 1'b0;  // ROM write, single wait cycle
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mem_start) begin
			mem.we    <= cpu_wr;
			mem.addr  <= map_addr;
			mem.wdata <= cpu_dout;
		end
		if (mem.req && mem.ack && !mem.we)
			cpu_din <= mem.rdata;  // Held until the next read
	end

	// ROM images are only written by the loader
	a_no_rom_write: assert property (@(posedge clk_sys) disable iff (reset)
		mem.req && mem.we |-> !in_rom_area(mem.addr));

endmodule

//--- src/dma_loader.sv
`timescale 1ns/1ps

module dma_loader
	import zx_mem_pkg::*;
#(
	parameter ram_addr_t LOAD_BASE_ROM = ROM_AREA,
	parameter ram_addr_t TAPE_BASE     = 23'h400000
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      ioctl_download,
	input  logic      ioctl_wr,
	input  byte_t     ioctl_index,
	input  byte_t     ioctl_dout,
	output logic      ioctl_wait,
	output ram_addr_t tape_len,
	output logic      tape_new,  // Start of a tape download
	mem_req_if.requester mem
);

	logic      dl_d;
	ram_addr_t offset;  // Running byte count

	wire dl_rise  = ioctl_download & ~dl_d;
	wire dl_fall  = ~ioctl_download & dl_d;
	wire idx_rom  = (ioctl_index == LOAD_IDX_ROM);
	wire idx_tape = (ioctl_index == LOAD_IDX_TAPE);
	wire wr_go    = ioctl_download & ioctl_wr & (idx_rom | idx_tape);

	assign mem.we = 1'b1;  // Write-only channel

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_d       <= 1'b0;
			offset     <= '0;
			tape_len   <= '0;
			tape_new   <= 1'b0;
			ioctl_wait <= 1'b0;
			mem.req    <= 1'b0;
		end else begin
			dl_d     <= ioctl_download;
			tape_new <= dl_rise & idx_tape;
			if (dl_rise) begin
				offset <= '0;
				if (idx_tape)
					tape_len <= '0;  // Nothing to play until the download ends
			end else if (wr_go) begin
				offset     <= offset + 1'b1;
				ioctl_wait <= 1'b1;
				mem.req    <= 1'b1;
			end else if (mem.req && mem.ack) begin
				ioctl_wait <= 1'b0;
				mem.req    <= 1'b0;
			end
			if (dl_fall && idx_tape)
				tape_len <= offset;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_go) begin
			mem.addr  <= (idx_rom ? LOAD_BASE_ROM : TAPE_BASE) + offset;
			mem.wdata <= ioctl_dout;
		end
	end

endmodule

//--- src/tape_fetch.sv
`timescale 1ns/1ps

module tape_fetch
	import zx_mem_pkg::*;
#(
	parameter ram_addr_t TAPE_BASE = 23'h400000
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  ram_addr_t tape_len,
	input  logic      tape_new,
	input  logic      tape_play,
	input  logic      tape_ready,
	output byte_t     tape_byte,
	output logic      tape_valid,
	output logic      tape_end,
	mem_req_if.requester mem
);

	ram_addr_t rd_cnt;  // Bytes fetched so far
	logic      drop;    // Read in flight belongs to the old tape

	wire issue   = tape_play & ~mem.req & ~tape_valid & (rd_cnt < tape_len) & ~tape_new;
	wire got     = mem.req & mem.ack;
	wire consume = tape_valid & tape_ready;

	assign mem.we    = 1'b0;
	assign mem.wdata = '0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_cnt     <= '0;
			drop       <= 1'b0;
			tape_valid <= 1'b0;
			tape_end   <= 1'b0;
			mem.req    <= 1'b0;
		end else begin
			if (issue)
				mem.req <= 1'b1;
			if (got) begin
				mem.req <= 1'b0;
				drop    <= 1'b0;
				if (!drop) begin
					tape_valid <= 1'b1;
					rd_cnt     <= rd_cnt + 1'b1;
				end
			end
			if (consume) begin
				tape_valid <= 1'b0;
				if (rd_cnt == tape_len)
					tape_end <= 1'b1;  // Last byte taken
			end
			// Rewind on a new tape download
			if (tape_new) begin
				rd_cnt     <= '0;
				tape_valid <= 1'b0;
				tape_end   <= 1'b0;
				drop       <= mem.req & ~mem.ack;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (issue)
			mem.addr <= TAPE_BASE + rd_cnt;
		if (got && !drop)
			tape_byte <= mem.rdata;
	end

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
	import zx_mem_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	mem_req_if.server    cpu_ch,
	mem_req_if.server    load_ch,
	mem_req_if.server    tape_ch,
	mem_req_if.requester ram_ch
);

	localparam int G_LOAD = 0;
	localparam int G_TAPE = 1;
	localparam int G_CPU  = 2;

	logic [2:0] grant;  // One-hot, zero when idle
	logic [2:0] pick;   // Highest-priority request

	// Loader over tape over CPU
	always_comb begin
		pick         = '0;
		pick[G_LOAD] = load_ch.req;
		pick[G_TAPE] = tape_ch.req & ~load_ch.req;
		pick[G_CPU]  = cpu_ch.req & ~tape_ch.req & ~load_ch.req;
	end

	// ====================
	// Grant register
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			grant <= '0;
		end else if (grant == '0) begin
			grant <= pick;
		end else if (ram_ch.ack) begin
			grant <= '0;  // Rearbitrate next cycle
		end
	end

	// Field mux towards the RAM
	assign ram_ch.req = |grant;

	always_comb begin
		case (grant)
			3'b001: begin
				ram_ch.we    = load_ch.we;
				ram_ch.addr  = load_ch.addr;
				ram_ch.wdata = load_ch.wdata;
			end
			3'b010: begin
				ram_ch.we    = tape_ch.we;
				ram_ch.addr  = tape_ch.addr;
				ram_ch.wdata = tape_ch.wdata;
			end
			default: begin
				ram_ch.we    = cpu_ch.we & grant[G_CPU];  // No write when idle
				ram_ch.addr  = cpu_ch.addr;
				ram_ch.wdata = cpu_ch.wdata;
			end
		endcase
	end

	// Ack routing
	assign load_ch.ack   = grant[G_LOAD] & ram_ch.ack;
	assign tape_ch.ack   = grant[G_TAPE] & ram_ch.ack;
	assign cpu_ch.ack    = grant[G_CPU] & ram_ch.ack;
	assign load_ch.rdata = ram_ch.rdata;
	assign tape_ch.rdata = ram_ch.rdata;
	assign cpu_ch.rdata  = ram_ch.rdata;

	a_grant_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(grant));

	// Acks only reach a granted channel that is still requesting
	a_ack_granted: assert property (@(posedge clk_sys) disable iff (reset)
		(load_ch.ack |-> load_ch.req) and (tape_ch.ack |-> tape_ch.req) and
		(cpu_ch.ack |-> cpu_ch.req));

endmodule

//--- src/ram_core.sv
`timescale 1ns/1ps

module ram_core
	import zx_mem_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	mem_req_if.server mem
);

	byte_t      ram [0:2**RAM_ADDR_W-1];
	logic [1:0] busy_cnt;  // 0 idle, 1 read stage, 2 ack

	assign mem.ack = (busy_cnt == 2'd2);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy_cnt <= 2'd0;
		end else begin
			case (busy_cnt)
				2'd0:    if (mem.req) busy_cnt <= 2'd1;
				2'd1:    busy_cnt <= 2'd2;
				default: busy_cnt <= 2'd0;
			endcase
		end
	end

	// Data path
	always_ff @(posedge clk_sys) begin
		if (busy_cnt == 2'd1)
			mem.rdata <= ram[mem.addr];
		if (mem.ack && mem.we)
			ram[mem.addr] <= mem.wdata;  // Lands at the ack edge
	end

	a_ack_after_req: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mem.ack) |-> $past(mem.req, 2));

endmodule

//--- src/zx_mem_top.sv
`timescale 1ns/1ps

module zx_mem_top
	import zx_mem_pkg::*;
#(
	parameter ram_addr_t LOAD_BASE_ROM = ROM_AREA,
	parameter ram_addr_t TAPE_BASE     = 23'h400000
) (
	input  logic      clk_sys,
	input  logic      reset,
	// CPU bus
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_mreq,
	input  logic      cpu_rd,
	input  logic      cpu_wr,
	input  logic      cpu_iorq,
	input  byte_t     cpu_dout,
	output byte_t     cpu_din,
	output logic      cpu_wait,
	// Download stream
	input  logic      ioctl_download,
	input  byte_t     ioctl_index,
	input  logic      ioctl_wr,
	input  byte_t     ioctl_dout,
	output logic      ioctl_wait,
	// Tape stream
	input  logic      tape_play,
	input  logic      tape_ready,
	output byte_t     tape_byte,
	output logic      tape_valid,
	output logic      tape_end
);

	ram_addr_t tape_len;
	logic      tape_new;

	mem_req_if cpu_ch ();
	mem_req_if load_ch ();
	mem_req_if tape_ch ();
	mem_req_if ram_ch ();

	page_mapper u_page_mapper (
		.clk_sys, .reset, .cpu_addr, .cpu_mreq, .cpu_rd, .cpu_wr, .cpu_iorq,
		.cpu_dout, .cpu_din, .cpu_wait,
		.mem (cpu_ch.requester)
	);

	dma_loader #(
		.LOAD_BASE_ROM (LOAD_BASE_ROM),
		.TAPE_BASE     (TAPE_BASE)
	) u_dma_loader (
		.clk_sys, .reset, .ioctl_download, .ioctl_wr, .ioctl_index, .ioctl_dout,
		.ioctl_wait, .tape_len, .tape_new,
		.mem (load_ch.requester)
	);

	tape_fetch #(.TAPE_BASE(TAPE_BASE)) u_tape_fetch (
		.clk_sys, .reset, .tape_len, .tape_new, .tape_play, .tape_ready,
		.tape_byte, .tape_valid, .tape_end,
		.mem (tape_ch.requester)
	);

	mem_arbiter u_mem_arbiter (
		.clk_sys, .reset,
		.cpu_ch  (cpu_ch.server),
		.load_ch (load_ch.server),
		.tape_ch (tape_ch.server),
		.ram_ch  (ram_ch.requester)
	);

	ram_core u_ram_core (
		.clk_sys, .reset,
		.mem (ram_ch.server)
	);

endmodule

//--- testbench/tb_zx_mem.sv
`timescale 1ns/1ps

module tb_zx_mem
	import zx_mem_pkg::*;
();

	localparam ram_addr_t LOAD_BASE  = ROM_AREA;
	localparam ram_addr_t TAPE_BASE  = 23'h400000;
	localparam int        ROM_DL_LEN = 16384 + 64;  // ROM 0 start through ROM 1 start
	localparam int        N_ACCESS   = 600;
	localparam int        DL_BYTES   = ROM_DL_LEN + 40 + 24 + 32;
	localparam int        WATCH_CYCLES = N_ACCESS * 20 + DL_BYTES * 10;

	logic      clk_sys, reset;
	cpu_addr_t cpu_addr;
	logic      cpu_mreq, cpu_rd, cpu_wr, cpu_iorq, cpu_wait;
	byte_t     cpu_dout, cpu_din;
	logic      ioctl_download, ioctl_wr, ioctl_wait;
	byte_t     ioctl_index, ioctl_dout;
	logic      tape_play, tape_ready, tape_valid, tape_end;
	byte_t     tape_byte;

	integer    seed = 32'h495d;
	int        n_err = 0;
	int        n_checks = 0;
	byte_t     shadow [ram_addr_t];  // Expected RAM contents
	byte_t     tape_q [$];           // Tape bytes still to come out
	byte_t     page_m;               // Model of port 7FFD
	byte_t     rd_exp;
	logic      rd_pend = 1'b0;
	logic      wait_q = 1'b0;

	zx_mem_top #(.LOAD_BASE_ROM(LOAD_BASE), .TAPE_BASE(TAPE_BASE)) i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ====================
	// Reference model
	// ====================
	function automatic ram_addr_t ref_ram_addr(input cpu_addr_t a, input byte_t pg);
		ram_addr_t ofs;
		ofs = ram_addr_t'(a[13:0]);
		case (a[15:14])
			2'd0:    return ROM_AREA + (pg[4] ? 23'h4000 : 23'h0) + ofs;
			2'd1:    return 23'h14000 + ofs;  // Bank 5
			2'd2:    return 23'h08000 + ofs;  // Bank 2
			default: return (ram_addr_t'(pg[2:0]) << 14) + ofs;
		endcase
	endfunction

	function automatic byte_t rand_byte();
		return byte_t'($random(seed));
	endfunction

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] %0d ns: %s got %02h expected %02h", $time, what, got, exp);
			n_err++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] %0d ns: %s is %b expected %b", $time, what, got, exp);
			n_err++;
		end
	endtask

	// Compare process, sampled mid-cycle
	always @(negedge clk_sys) begin
		if (wait_q && !cpu_wait && rd_pend) begin
			check_byte("cpu read", cpu_din, rd_exp);
			rd_pend = 1'b0;
		end
		wait_q = cpu_wait;
		if (tape_valid && tape_ready) begin
			if (tape_q.size() == 0) begin
				$display("Tape byte %02h came out after the end of the tape", tape_byte);
				n_err++;
			end else begin
				check_byte("tape byte", tape_byte, tape_q.pop_front());
			end
			check_flag("tape_end before last byte", tape_end, 1'b0);
		end
	end

	// ====================
	// Bus tasks
	// ====================
	task automatic run_bus_cycle();
		do @(negedge clk_sys); while (!cpu_wait);
		do @(negedge clk_sys); while (cpu_wait);
		@(posedge clk_sys);
		cpu_mreq <= 1'b0;
		cpu_rd   <= 1'b0;
		cpu_wr   <= 1'b0;
	endtask

	task automatic cpu_write(input cpu_addr_t a, input byte_t d);
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_dout <= d;
		cpu_wr   <= 1'b1;
		cpu_mreq <= 1'b1;
		run_bus_cycle();
		if (a[15:14] != 2'd0)
			shadow[ref_ram_addr(a, page_m)] = d;  // ROM window ignores writes
	endtask

	task automatic cpu_read(input cpu_addr_t a);
		ram_addr_t ra;
		ra = ref_ram_addr(a, page_m);
		if (!shadow.exists(ra)) begin
			$display("No expected data for CPU address %04h", a);
			n_err++;
			return;
		end
		rd_exp  = shadow[ra];
		rd_pend = 1'b1;
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_rd   <= 1'b1;
		cpu_mreq <= 1'b1;
		run_bus_cycle();
	endtask

	task automatic io_write(input byte_t v);
		@(posedge clk_sys);
		cpu_addr <= 16'h7FFD;
		cpu_dout <= v;
		cpu_iorq <= 1'b1;
		cpu_wr   <= 1'b1;
		@(posedge clk_sys);
		cpu_iorq <= 1'b0;
		cpu_wr   <= 1'b0;
		@(posedge clk_sys);
		if (!page_m[5])
			page_m = v;  // Locked register keeps its value
	endtask

	task automatic download(input byte_t idx, input int n, input logic is_tape);
		ram_addr_t base;
		byte_t     d;
		base = is_tape ? TAPE_BASE : LOAD_BASE;
		if (is_tape)
			tape_q.delete();
		@(posedge clk_sys);
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (int i = 0; i < n; i++) begin
			d = rand_byte();
			shadow[base + ram_addr_t'(i)] = d;
			if (is_tape)
				tape_q.push_back(d);
			ioctl_dout <= d;
			ioctl_wr   <= 1'b1;
			@(posedge clk_sys);
			ioctl_wr <= 1'b0;
			do @(negedge clk_sys); while (ioctl_wait);
			@(posedge clk_sys);
		end
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic play_tape();
		@(posedge clk_sys);
		tape_play <= 1'b1;
		forever begin
			@(posedge clk_sys);
			tape_ready <= ($random(seed) & 3) != 0;  // Random gaps
			@(negedge clk_sys);
			if (tape_end)
				break;
		end
		check_flag("all tape bytes seen", tape_q.size() == 0, 1'b1);
		@(posedge clk_sys);
		tape_play  <= 1'b0;
		tape_ready <= 1'b0;
	endtask

	task automatic cpu_mix(input int n);
		cpu_addr_t a;
		for (int i = 0; i < n; i++) begin
			a = cpu_addr_t'($random(seed));
			if (a[15:14] == 2'd0)
				a[15:14] = 2'd1;  // Keep out of the ROM window
			cpu_write(a, rand_byte());
			cpu_read(a);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (8) @(posedge clk_sys);
		reset  <= 1'b0;
		page_m = 8'h00;
		@(negedge clk_sys);
		check_flag("cpu_wait after reset", cpu_wait, 1'b0);
		check_flag("ioctl_wait after reset", ioctl_wait, 1'b0);
		check_flag("tape_valid after reset", tape_valid, 1'b0);
		check_flag("tape_end after reset", tape_end, 1'b0);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		reset = 1'b1;
		cpu_addr = '0;
		cpu_mreq = 1'b0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_iorq = 1'b0;
		cpu_dout = '0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_dout = '0;
		tape_play = 1'b0;
		tape_ready = 1'b0;
		apply_reset();

		// Both ROM images in one stream
		download(LOAD_IDX_ROM, ROM_DL_LEN, 1'b0);
		for (int i = 0; i < 64; i++)
			cpu_read(cpu_addr_t'(i));
		io_write(8'h10);
		for (int i = 0; i < 64; i++)
			cpu_read(cpu_addr_t'(i));
		for (int i = 0; i < 16; i++) begin
			cpu_write(cpu_addr_t'(i * 3), rand_byte());
			cpu_read(cpu_addr_t'(i * 3));
		end

		// Fixed windows, then every bank at C000
		io_write(8'h00);
		for (int i = 0; i < 8; i++) begin
			cpu_write(16'h4000 + cpu_addr_t'(i * 97), rand_byte());
			cpu_write(16'h8000 + cpu_addr_t'(i * 97), rand_byte());
		end
		for (int b = 0; b < 8; b++) begin
			io_write(byte_t'(b));
			for (int i = 0; i < 8; i++)
				cpu_write(16'hC000 + cpu_addr_t'(b * 8 + i * 211), rand_byte());
			for (int i = 0; i < 8; i++)
				cpu_read(16'hC000 + cpu_addr_t'(b * 8 + i * 211));
			if (b == 5 || b == 2)
				for (int i = 0; i < 8; i++)
					cpu_read(16'hC000 + cpu_addr_t'(i * 97));
		end
		for (int i = 0; i < 8; i++) begin
			cpu_read(16'h4000 + cpu_addr_t'(i * 97));
			cpu_read(16'h8000 + cpu_addr_t'(i * 97));
		end

		// Lock holds bank 3 until reset
		io_write(8'h23);
		io_write(8'h06);
		cpu_read(16'hC000 + 16'd24);
		cpu_write(16'hC005, rand_byte());
		cpu_read(16'hC005);
		apply_reset();
		io_write(8'h06);
		cpu_read(16'hC000 + 16'd48);

		download(LOAD_IDX_TAPE, 40, 1'b1);
		play_tape();

		// Everything at once
		fork
			download(LOAD_IDX_TAPE, 24, 1'b1);
			cpu_mix(40);
		join
		check_flag("tape_end after new tape download", tape_end, 1'b0);
		fork
			play_tape();
			download(LOAD_IDX_ROM, 32, 1'b0);
			cpu_mix(40);
		join

		repeat (4) @(posedge clk_sys);
		$display("Checks: %0d, errors: %0d", n_checks, n_err);
		if (n_err == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		repeat (WATCH_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the test did not complete", WATCH_CYCLES);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- zx_mem_top.f
src/zx_mem_pkg.sv
src/mem_req_if.sv
src/page_mapper.sv
src/dma_loader.sv
src/tape_fetch.sv
src/mem_arbiter.sv
src/ram_core.sv
src/zx_mem_top.sv
testbench/tb_zx_mem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_zx_mem
FILELIST  ?= zx_mem_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Regression passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
